//--- common/sd_ctrl_cfg.svh
`ifndef SD_CTRL_CFG_SVH
`define SD_CTRL_CFG_SVH

// Wishbone slave byte offsets
`define SD_ADR_ARGUMENT    8'h00
`define SD_ADR_COMMAND     8'h04
`define SD_ADR_STATUS      8'h08
`define SD_ADR_RESP1       8'h0C
`define SD_ADR_CONTROLLER  8'h1C
`define SD_ADR_BLOCK       8'h20
`define SD_ADR_POWER       8'h24
`define SD_ADR_SOFTWARE    8'h28
`define SD_ADR_TIMEOUT     8'h2C
`define SD_ADR_NORMAL_ISR  8'h30
`define SD_ADR_ERROR_ISR   8'h34
`define SD_ADR_NORMAL_ISER 8'h38
`define SD_ADR_ERROR_ISER  8'h3C
`define SD_ADR_CAPA        8'h48
`define SD_ADR_CLOCK_D     8'h4C

`define SD_POWER_VALUE      8'h0F  // 3.3 V supply, power on
`define SD_BLOCK_SIZE       16'd512
`define SD_CONTROLLER_VALUE 16'h0000  // 1-bit bus
`define SD_CAPA_VALUE       16'h0000

`define SD_RESET_CLK_DIV 8'd2

`define SD_CMD_FRAME_BITS 48
`define SD_CMD_CRC_BITS   40

`endif

//--- common/sd_ctrl_pkg.sv
package sd_ctrl_pkg;

  // Command register layout
  typedef struct packed {
    logic [1:0] rsvd_hi;
    logic [5:0] cmd_index;
    logic [2:0] rsvd_mid;
    logic       index_check;
    logic       crc_check;
    logic       rsvd_lo;
    logic [1:0] resp_type;  // 0 none, anything else short
  } cmd_setting_t;

  typedef struct packed {
    cmd_setting_t setting;
    logic [31:0]  argument;
  } cmd_req_t;

  // Also the low nibble of the error status register
  typedef struct packed {
    logic end_bit;
    logic index;
    logic crc;
    logic timeout;
  } cmd_err_t;

  // One-cycle strobes marking the SD clock edges
  typedef struct packed {
    logic rise;
    logic fall;
  } sd_clk_t;

  typedef struct packed {
    logic [7:0]  adr;
    logic [31:0] dat;
    logic        we;
    logic        cyc;
    logic        stb;
  } wb_req_t;

  typedef struct packed {
    logic        done;  // Result valid
    logic [5:0]  index;
    logic [31:0] status;
    logic        crc_bad;
    logic        end_bad;
  } serial_rsp_t;

endpackage

//--- source/sd_clock_divider.sv
`timescale 1ns/100ps
`include "sd_ctrl_cfg.svh"

module sd_clock_divider (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic [7:0]            clock_divider_i,
  output logic                  sd_clk_o,
  output sd_ctrl_pkg::sd_clk_t  sd_clk_edge_o
);

  logic [7:0] cnt_q;
  logic [7:0] div_q;  // Divider in use for the current half period
  logic       reload;

  assign reload = (cnt_q == div_q);

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      cnt_q         <= 8'd0;
      div_q         <= `SD_RESET_CLK_DIV;
      sd_clk_o      <= 1'b0;
      sd_clk_edge_o <= '0;
    end else begin
      sd_clk_edge_o <= '0;
      if (reload) begin
        cnt_q              <= 8'd0;
        div_q              <= clock_divider_i;  // New value picked up here
        sd_clk_o           <= ~sd_clk_o;
        sd_clk_edge_o.rise <= ~sd_clk_o;
        sd_clk_edge_o.fall <= sd_clk_o;
      end else begin
        cnt_q <= cnt_q + 8'd1;
      end
    end
  end

endmodule

//--- sd_cmd/sd_cmd_serial.sv
`timescale 1ns/100ps
`include "sd_ctrl_cfg.svh"

module sd_cmd_serial (
  input  logic                      wb_clk_i,
  input  logic                      rst_i,
  input  sd_ctrl_pkg::sd_clk_t      sd_clk_edge_i,
  input  logic                      start_i,
  input  sd_ctrl_pkg::cmd_req_t     req_i,
  input  logic [15:0]               timeout_i,
  input  logic                      sd_cmd_dat_i,
  output logic                      sd_cmd_out_o,
  output logic                      sd_cmd_oe_o,
  output sd_ctrl_pkg::serial_rsp_t  rsp_o,
  output logic                      timed_out_o
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_SEND = 2'd1;
  localparam logic [1:0] ST_WAIT = 2'd2;
  localparam logic [1:0] ST_RECV = 2'd3;
  localparam logic [5:0] CRC_BITS = 6'(`SD_CMD_CRC_BITS);
  localparam logic [5:0] LAST_BIT = 6'(`SD_CMD_FRAME_BITS - 1);

  logic [1:0]  state_q;
  logic [5:0]  bit_cnt_q;
  logic [15:0] wait_cnt_q;
  logic        resp_en_q;
  logic        done_q;
  logic [39:0] tx_sreg_q;  // Start, transmission, index, argument
  logic [45:0] rx_sreg_q;  // Response bits 1 to 46
  logic [6:0]  crc_q;
  logic        crc_bad_q;
  logic        end_bad_q;
  logic        crc_in;
  logic        crc_fb;
  logic [6:0]  crc_next;
  logic        send_end;
  logic        rx_end;

  // CRC7, x^7 + x^3 + 1
  assign crc_in   = (state_q == ST_SEND) ? tx_sreg_q[39] : sd_cmd_dat_i;
  assign crc_fb   = crc_q[6] ^ crc_in;
  assign crc_next = {crc_q[5:3], crc_q[2] ^ crc_fb, crc_q[1:0], crc_fb};

  // Extra fall after the end bit releases the line
  assign send_end = (state_q == ST_SEND) && sd_clk_edge_i.fall &&
                    (bit_cnt_q == LAST_BIT + 6'd1);
  assign rx_end   = (state_q == ST_RECV) && sd_clk_edge_i.rise && (bit_cnt_q == LAST_BIT);

  assign rsp_o = '{done: done_q, index: rx_sreg_q[44:39], status: rx_sreg_q[38:7],
                   crc_bad: crc_bad_q, end_bad: end_bad_q};

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q      <= ST_IDLE;
      bit_cnt_q    <= 6'd0;
      wait_cnt_q   <= 16'd0;
      resp_en_q    <= 1'b0;
      done_q       <= 1'b0;
      timed_out_o  <= 1'b0;
      sd_cmd_out_o <= 1'b1;
      sd_cmd_oe_o  <= 1'b0;
    end else begin
      done_q      <= 1'b0;
      timed_out_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q   <= ST_SEND;
            bit_cnt_q <= 6'd0;
            resp_en_q <= (req_i.setting.resp_type != 2'd0);
          end
        end
        ST_SEND: begin
          if (sd_clk_edge_i.fall) begin
            bit_cnt_q   <= bit_cnt_q + 6'd1;
            sd_cmd_oe_o <= 1'b1;
            if (bit_cnt_q < CRC_BITS) begin
              sd_cmd_out_o <= tx_sreg_q[39];
            end else if (bit_cnt_q < LAST_BIT) begin
              sd_cmd_out_o <= crc_q[6];
            end else begin
              sd_cmd_out_o <= 1'b1;  // End bit, then idle level
            end
            if (send_end) begin
              sd_cmd_oe_o <= 1'b0;
              bit_cnt_q   <= 6'd0;
              wait_cnt_q  <= 16'd0;
              if (resp_en_q) begin
                state_q <= ST_WAIT;
              end else begin
                state_q <= ST_IDLE;
                done_q  <= 1'b1;
              end
            end
          end
        end
        ST_WAIT: begin
          if (sd_clk_edge_i.rise) begin
            if (!sd_cmd_dat_i) begin
              state_q   <= ST_RECV;  // Start bit seen
              bit_cnt_q <= 6'd1;
            end else if (wait_cnt_q == timeout_i) begin
              state_q     <= ST_IDLE;
              timed_out_o <= 1'b1;
            end else begin
              wait_cnt_q <= wait_cnt_q + 16'd1;
            end
          end
        end
        default: begin
          if (sd_clk_edge_i.rise) begin
            bit_cnt_q <= bit_cnt_q + 6'd1;
            if (rx_end) begin
              state_q <= ST_IDLE;
              done_q  <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if ((state_q == ST_IDLE) && start_i) begin
      tx_sreg_q <= {1'b0, 1'b1, req_i.setting.cmd_index, req_i.argument};
      crc_q     <= 7'd0;
    end
    if ((state_q == ST_SEND) && sd_clk_edge_i.fall) begin
      if (bit_cnt_q < CRC_BITS) begin
        tx_sreg_q <= {tx_sreg_q[38:0], 1'b0};
        crc_q     <= crc_next;
      end else begin
        crc_q <= {crc_q[5:0], 1'b0};  // Shift CRC out MSB first
      end
    end
    if (send_end) begin
      crc_bad_q <= 1'b0;
      end_bad_q <= 1'b0;
    end
    if ((state_q == ST_WAIT) && sd_clk_edge_i.rise && !sd_cmd_dat_i) begin
      crc_q <= 7'd0;  // A zero start bit leaves CRC at zero
    end
    if ((state_q == ST_RECV) && sd_clk_edge_i.rise) begin
      if (bit_cnt_q < LAST_BIT) begin
        rx_sreg_q <= {rx_sreg_q[44:0], sd_cmd_dat_i};
      end
      if (bit_cnt_q < CRC_BITS) begin
        crc_q <= crc_next;
      end
      if (rx_end) begin
        crc_bad_q <= (rx_sreg_q[6:0] != crc_q);
        end_bad_q <= !sd_cmd_dat_i;
      end
    end
  end

  // Card owns the line for the whole response window
  a_no_oe_in_rx: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    ((state_q == ST_WAIT) || (state_q == ST_RECV)) |-> !sd_cmd_oe_o);

  a_done_xor_timeout: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    !(rsp_o.done && timed_out_o));

endmodule

//--- sd_cmd/sd_cmd_master.sv
`timescale 1ns/100ps

module sd_cmd_master (
  input  logic                   wb_clk_i,
  input  logic                   rst_i,
  input  logic                   new_cmd_i,
  input  sd_ctrl_pkg::cmd_req_t  req_i,
  input  logic [15:0]            timeout_i,
  input  logic                   normal_clr_i,
  input  logic                   error_clr_i,
  input  sd_ctrl_pkg::sd_clk_t   sd_clk_edge_i,
  input  logic                   sd_cmd_dat_i,
  output logic                   sd_cmd_out_o,
  output logic                   sd_cmd_oe_o,
  output logic                   busy_o,
  output logic [31:0]            resp_o,
  output logic [15:0]            normal_isr_o,
  output logic [15:0]            error_isr_o
);

  sd_ctrl_pkg::cmd_req_t    req_q;
  sd_ctrl_pkg::cmd_err_t    err_q;
  sd_ctrl_pkg::cmd_err_t    err_set;
  sd_ctrl_pkg::serial_rsp_t srsp;
  logic                     start_q;
  logic                     complete_q;
  logic                     timed_out;
  logic                     resp_en;

  assign resp_en = (req_q.setting.resp_type != 2'd0);

  always_comb begin
    err_set         = '0;
    err_set.timeout = timed_out;
    if (srsp.done && resp_en) begin
      err_set.crc     = req_q.setting.crc_check & srsp.crc_bad;
      err_set.index   = req_q.setting.index_check &
                        (srsp.index != req_q.setting.cmd_index);
      err_set.end_bit = srsp.end_bad;  // Always checked
    end
  end

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      busy_o     <= 1'b0;
      start_q    <= 1'b0;
      complete_q <= 1'b0;
      err_q      <= '0;
      resp_o     <= 32'd0;
    end else begin
      start_q <= 1'b0;
      if (new_cmd_i && !busy_o) begin
        busy_o  <= 1'b1;
        start_q <= 1'b1;
      end
      if (srsp.done || timed_out) begin
        busy_o     <= 1'b0;
        complete_q <= 1'b1;  // Set wins over a clear in the same cycle
      end else if (normal_clr_i) begin
        complete_q <= 1'b0;
      end
      err_q <= (error_clr_i ? sd_ctrl_pkg::cmd_err_t'(4'd0) : err_q) | err_set;
      if (srsp.done && resp_en) begin
        resp_o <= srsp.status;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (new_cmd_i && !busy_o) begin
      req_q <= req_i;
    end
  end

  assign normal_isr_o = {15'd0, complete_q};
  assign error_isr_o  = {12'd0, err_q};

  sd_cmd_serial i_sd_cmd_serial (
    .wb_clk_i      (wb_clk_i),
    .rst_i         (rst_i),
    .sd_clk_edge_i (sd_clk_edge_i),
    .start_i       (start_q),
    .req_i         (req_q),
    .timeout_i     (timeout_i),
    .sd_cmd_dat_i  (sd_cmd_dat_i),
    .sd_cmd_out_o  (sd_cmd_out_o),
    .sd_cmd_oe_o   (sd_cmd_oe_o),
    .rsp_o         (srsp),
    .timed_out_o   (timed_out)
  );

  // Serializer has released the line whenever a start is given
  a_start_line_idle: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    start_q |-> (sd_cmd_out_o && !sd_cmd_oe_o));

endmodule

//--- source/sd_wb_regs.sv
`timescale 1ns/100ps
`include "sd_ctrl_cfg.svh"

module sd_wb_regs (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  sd_ctrl_pkg::wb_req_t   wb_req_i,
  output logic [31:0]            wb_dat_o,
  output logic                   wb_ack_o,
  output sd_ctrl_pkg::cmd_req_t  cmd_req_o,
  output logic                   new_cmd_o,
  output logic [15:0]            timeout_o,
  output logic [7:0]             clock_divider_o,
  output logic                   soft_reset_o,
  output logic                   normal_clr_o,
  output logic                   error_clr_o,
  input  logic                   busy_i,
  input  logic [31:0]            resp_i,
  input  logic [15:0]            normal_isr_i,
  input  logic [15:0]            error_isr_i,
  output logic                   int_a_o,
  output logic                   int_b_o
);

  logic [7:0]  software_q;
  logic [15:0] normal_iser_q;
  logic [15:0] error_iser_q;
  logic        access;
  logic        wr;

  // Access is taken in the cycle the ack is raised
  assign access = wb_req_i.cyc & wb_req_i.stb & ~wb_ack_o;
  assign wr     = access & wb_req_i.we;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wb_ack_o        <= 1'b0;
      new_cmd_o       <= 1'b0;
      normal_clr_o    <= 1'b0;
      error_clr_o     <= 1'b0;
      cmd_req_o       <= '0;
      software_q      <= 8'd0;
      timeout_o       <= 16'd0;
      normal_iser_q   <= 16'd0;
      error_iser_q    <= 16'd0;
      clock_divider_o <= `SD_RESET_CLK_DIV;
    end else begin
      wb_ack_o     <= access;
      new_cmd_o    <= 1'b0;
      normal_clr_o <= 1'b0;
      error_clr_o  <= 1'b0;
      if (wr) begin
        case (wb_req_i.adr)
          `SD_ADR_ARGUMENT: begin
            cmd_req_o.argument <= wb_req_i.dat;
            new_cmd_o          <= 1'b1;  // Argument write launches the command
          end
          `SD_ADR_COMMAND:     cmd_req_o.setting <= sd_ctrl_pkg::cmd_setting_t'(wb_req_i.dat[15:0]);
          `SD_ADR_SOFTWARE:    software_q      <= wb_req_i.dat[7:0];
          `SD_ADR_TIMEOUT:     timeout_o       <= wb_req_i.dat[15:0];
          `SD_ADR_NORMAL_ISER: normal_iser_q   <= wb_req_i.dat[15:0];
          `SD_ADR_ERROR_ISER:  error_iser_q    <= wb_req_i.dat[15:0];
          `SD_ADR_NORMAL_ISR:  normal_clr_o    <= 1'b1;
          `SD_ADR_ERROR_ISR:   error_clr_o     <= 1'b1;
          `SD_ADR_CLOCK_D:     clock_divider_o <= wb_req_i.dat[7:0];
          default: ;
        endcase
      end
    end
  end

  // Readback, valid with the ack
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      case (wb_req_i.adr)
        `SD_ADR_ARGUMENT:    wb_dat_o <= cmd_req_o.argument;
        `SD_ADR_COMMAND:     wb_dat_o <= {16'd0, cmd_req_o.setting};
        `SD_ADR_STATUS:      wb_dat_o <= {31'd0, busy_i};
        `SD_ADR_RESP1:       wb_dat_o <= resp_i;
        `SD_ADR_CONTROLLER:  wb_dat_o <= 32'(`SD_CONTROLLER_VALUE);
        `SD_ADR_BLOCK:       wb_dat_o <= 32'(`SD_BLOCK_SIZE);
        `SD_ADR_POWER:       wb_dat_o <= 32'(`SD_POWER_VALUE);
        `SD_ADR_SOFTWARE:    wb_dat_o <= {24'd0, software_q};
        `SD_ADR_TIMEOUT:     wb_dat_o <= {16'd0, timeout_o};
        `SD_ADR_NORMAL_ISR:  wb_dat_o <= {16'd0, normal_isr_i};
        `SD_ADR_ERROR_ISR:   wb_dat_o <= {16'd0, error_isr_i};
        `SD_ADR_NORMAL_ISER: wb_dat_o <= {16'd0, normal_iser_q};
        `SD_ADR_ERROR_ISER:  wb_dat_o <= {16'd0, error_iser_q};
        `SD_ADR_CAPA:        wb_dat_o <= 32'(`SD_CAPA_VALUE);
        `SD_ADR_CLOCK_D:     wb_dat_o <= {24'd0, clock_divider_o};
        default:             wb_dat_o <= 32'd0;  // Unmapped
      endcase
    end
  end

  assign soft_reset_o = software_q[0];

  assign int_a_o = |(normal_isr_i & normal_iser_q);
  assign int_b_o = |(error_isr_i & error_iser_q);

endmodule

//--- source/sd_controller_top.sv
`timescale 1ns/100ps

module sd_controller_top (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  input  logic [7:0]  wb_adr_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic        wb_ack_o,
  input  logic        sd_cmd_dat_i,
  output logic        sd_cmd_out_o,
  output logic        sd_cmd_oe_o,
  output logic        sd_clk_o_pad,
  output logic        int_a,
  output logic        int_b
);

  sd_ctrl_pkg::wb_req_t  wb_req;
  sd_ctrl_pkg::cmd_req_t cmd_req;
  sd_ctrl_pkg::sd_clk_t  sd_clk_edge;
  logic [15:0] timeout;
  logic [7:0]  clock_divider;
  logic [31:0] resp;
  logic [15:0] normal_isr;
  logic [15:0] error_isr;
  logic        new_cmd;
  logic        soft_reset;
  logic        normal_clr;
  logic        error_clr;
  logic        busy;
  logic        cmd_rst;

  assign wb_req  = '{adr: wb_adr_i, dat: wb_dat_i, we: wb_we_i, cyc: wb_cyc_i, stb: wb_stb_i};
  assign cmd_rst = wb_rst_i | soft_reset;  // Software reset hits the command path only

  sd_wb_regs i_sd_wb_regs (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .wb_req_i        (wb_req),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .cmd_req_o       (cmd_req),
    .new_cmd_o       (new_cmd),
    .timeout_o       (timeout),
    .clock_divider_o (clock_divider),
    .soft_reset_o    (soft_reset),
    .normal_clr_o    (normal_clr),
    .error_clr_o     (error_clr),
    .busy_i          (busy),
    .resp_i          (resp),
    .normal_isr_i    (normal_isr),
    .error_isr_i     (error_isr),
    .int_a_o         (int_a),
    .int_b_o         (int_b)
  );

  sd_clock_divider i_sd_clock_divider (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .clock_divider_i (clock_divider),
    .sd_clk_o        (sd_clk_o_pad),
    .sd_clk_edge_o   (sd_clk_edge)
  );

  sd_cmd_master i_sd_cmd_master (
    .wb_clk_i      (wb_clk_i),
    .rst_i         (cmd_rst),
    .new_cmd_i     (new_cmd),
    .req_i         (cmd_req),
    .timeout_i     (timeout),
    .normal_clr_i  (normal_clr),
    .error_clr_i   (error_clr),
    .sd_clk_edge_i (sd_clk_edge),
    .sd_cmd_dat_i  (sd_cmd_dat_i),
    .sd_cmd_out_o  (sd_cmd_out_o),
    .sd_cmd_oe_o   (sd_cmd_oe_o),
    .busy_o        (busy),
    .resp_o        (resp),
    .normal_isr_o  (normal_isr),
    .error_isr_o   (error_isr)
  );

endmodule

//--- verification/sd_controller_tb.sv
`timescale 1ns/100ps
`include "sd_ctrl_cfg.svh"

module sd_controller_tb;

  localparam int TIMEOUT_VAL  = 20;
  localparam int SD_PERIOD_NS = 2 * (`SD_RESET_CLK_DIV + 1) * 8;
  localparam int CMD_SD_CLKS  = `SD_CMD_FRAME_BITS * 2 + TIMEOUT_VAL + 8;  // Frame, wait, response
  localparam int NUM_CMDS     = 17;
  localparam int WATCHDOG_NS  = NUM_CMDS * CMD_SD_CLKS * SD_PERIOD_NS + 50000;
  localparam int MAX_POLLS    = 2000;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic [7:0]  wb_adr_i;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_ack_o;
  logic        sd_cmd_dat_i;
  logic        sd_cmd_out_o;
  logic        sd_cmd_oe_o;
  logic        sd_clk_o_pad;
  logic        int_a;
  logic        int_b;

  logic [31:0] seed;
  int          errors;
  int          checks;
  int          tests;

  // Card model state
  logic        tx_bits[$];  // Command bits seen while oe is high
  logic        pad_q;
  logic        card_armed;
  logic        card_sending;
  logic [47:0] card_frame;
  int          card_delay;
  int          delay_cnt;
  int          card_bit;

  sd_controller_top i_sd_controller_top (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_adr_i     (wb_adr_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_ack_o     (wb_ack_o),
    .sd_cmd_dat_i (sd_cmd_dat_i),
    .sd_cmd_out_o (sd_cmd_out_o),
    .sd_cmd_oe_o  (sd_cmd_oe_o),
    .sd_clk_o_pad (sd_clk_o_pad),
    .int_a        (int_a),
    .int_b        (int_b)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #4 wb_clk_i = ~wb_clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests finished");
    $display("Errors found");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // CRC7 with generator x^7 + x^3 + 1, MSB first
  function automatic logic [6:0] crc7(input logic [39:0] bits);
    logic [6:0] c;
    logic       fb;
    c = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      fb = c[6] ^ bits[i];
      c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  function automatic logic [47:0] cmd_frame(input logic [5:0] idx, input logic [31:0] arg);
    logic [39:0] head;
    head = {2'b01, idx, arg};
    return {head, crc7(head), 1'b1};
  endfunction

  function automatic logic [47:0] resp_frame(input logic [5:0] idx, input logic [31:0] status,
                                             input logic [6:0] crc_flip, input logic end_bit);
    logic [39:0] head;
    head = {2'b00, idx, status};  // Card transmission bit is zero
    return {head, crc7(head) ^ crc_flip, end_bit};
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_setting(input string name, input sd_ctrl_pkg::cmd_setting_t exp,
                               input sd_ctrl_pkg::cmd_setting_t act);
    checks++;
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_err(input string name, input sd_ctrl_pkg::cmd_err_t exp,
                           input sd_ctrl_pkg::cmd_err_t act);
    checks++;
    if (exp !== act) begin
      $display("FAIL %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d mismatches", name, errors - errs_before);
    end
  endtask

  task automatic wb_cycle(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                          output logic [31:0] rdat);
    int waits;
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    waits    = 0;
    do begin
      @(negedge wb_clk_i);
      waits++;
    end while (!wb_ack_o && waits < 8);
    if (!wb_ack_o) begin
      $display("No Wishbone ack for an access to offset %h", adr);
      errors++;
    end
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
    wb_cycle(1'b0, adr, 32'd0, dat);
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int          polls;
    st    = 32'd1;
    polls = 0;
    while (st[0] && polls < MAX_POLLS) begin
      wb_read(`SD_ADR_STATUS, st);
      polls++;
    end
    if (st[0]) begin
      $display("Command still busy after %0d status polls", polls);
      errors++;
    end
  endtask

  task automatic launch_cmd(input sd_ctrl_pkg::cmd_setting_t setting, input logic [31:0] arg);
    wb_write(`SD_ADR_NORMAL_ISR, 32'd0);
    wb_write(`SD_ADR_ERROR_ISR, 32'd0);
    tx_bits.delete();
    wb_write(`SD_ADR_COMMAND, {16'd0, setting});
    wb_write(`SD_ADR_ARGUMENT, arg);  // Starts the command
  endtask

  task automatic arm_card(input logic [5:0] idx, input logic [31:0] status,
                          input logic [6:0] crc_flip, input logic end_bit, input int delay);
    card_frame   = resp_frame(idx, status, crc_flip, end_bit);
    card_delay   = delay;
    card_sending = 1'b0;
    card_armed   = 1'b1;
  endtask

  task automatic check_frame(input string name, input logic [47:0] exp);
    logic [47:0] got;
    got = '0;
    if (tx_bits.size() != `SD_CMD_FRAME_BITS) begin
      $display("%s: captured %0d command bits instead of 48", name, tx_bits.size());
      errors++;
    end else begin
      foreach (tx_bits[k]) got = {got[46:0], tx_bits[k]};
      check_word(name, exp[47:16], got[47:16]);
      check_word(name, {16'd0, exp[15:0]}, {16'd0, got[15:0]});
    end
  endtask

  task automatic check_done(input string name, input logic [31:0] exp_resp, input logic chk_resp,
                            input sd_ctrl_pkg::cmd_err_t exp_err);
    logic [31:0] rd;
    wb_read(`SD_ADR_NORMAL_ISR, rd);
    check_word({name, " complete"}, 32'd1, rd);
    wb_read(`SD_ADR_STATUS, rd);
    check_word({name, " busy"}, 32'd0, rd);
    wb_read(`SD_ADR_ERROR_ISR, rd);
    check_err({name, " errors"}, exp_err, sd_ctrl_pkg::cmd_err_t'(rd[3:0]));
    if (chk_resp) begin
      wb_read(`SD_ADR_RESP1, rd);
      check_word({name, " resp1"}, exp_resp, rd);
    end
  endtask

  // Card side, sampled and driven between wb_clk_i rising edges
  always @(negedge wb_clk_i) begin
    if (sd_clk_o_pad && !pad_q && sd_cmd_oe_o) begin
      tx_bits.push_back(sd_cmd_out_o);
      if (tx_bits.size() == `SD_CMD_FRAME_BITS && card_armed) begin
        card_armed   = 1'b0;
        card_sending = 1'b1;
        delay_cnt    = card_delay;
        card_bit     = 0;
      end
    end
    if (!sd_clk_o_pad && pad_q && card_sending) begin
      if (delay_cnt > 0) begin
        delay_cnt--;
      end else if (card_bit < 48) begin
        sd_cmd_dat_i = card_frame[47 - card_bit];
        card_bit++;
      end else begin
        sd_cmd_dat_i = 1'b1;  // Release the line
        card_sending = 1'b0;
      end
    end
    pad_q = sd_clk_o_pad;
  end

  initial begin
    logic [31:0]                r;
    logic [31:0]                rd;
    logic [31:0]                arg;
    logic [31:0]                status;
    logic [5:0]                 idx;
    sd_ctrl_pkg::cmd_setting_t  setting;
    sd_ctrl_pkg::cmd_err_t      exp_err;
    int                         first;
    int                         fault;
    seed         = 32'd85;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    wb_rst_i     = 1'b1;
    wb_dat_i     = 32'd0;
    wb_adr_i     = 8'd0;
    wb_we_i      = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    sd_cmd_dat_i = 1'b1;  // Pulled up while nobody drives
    pad_q        = 1'b0;
    card_armed   = 1'b0;
    card_sending = 1'b0;
    card_delay   = 0;
    repeat (10) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;

    first = errors;
    wb_read(`SD_ADR_POWER, rd);
    check_word("power", 32'(`SD_POWER_VALUE), rd);
    wb_read(`SD_ADR_BLOCK, rd);
    check_word("block size", 32'(`SD_BLOCK_SIZE), rd);
    wb_read(`SD_ADR_CONTROLLER, rd);
    check_word("controller", 32'(`SD_CONTROLLER_VALUE), rd);
    wb_read(`SD_ADR_CAPA, rd);
    check_word("capabilities", 32'(`SD_CAPA_VALUE), rd);
    wb_read(`SD_ADR_CLOCK_D, rd);
    check_word("reset divider", 32'(`SD_RESET_CLK_DIV), rd);
    wb_read(8'h40, rd);
    check_word("unmapped", 32'd0, rd);
    for (int i = 0; i < 3; i++) begin
      r = next_rand();
      wb_write(`SD_ADR_TIMEOUT, r);
      wb_read(`SD_ADR_TIMEOUT, rd);
      check_word("timeout readback", {16'd0, r[15:0]}, rd);
      r = next_rand();
      wb_write(`SD_ADR_NORMAL_ISER, r);
      wb_read(`SD_ADR_NORMAL_ISER, rd);
      check_word("normal enable readback", {16'd0, r[15:0]}, rd);
      r = next_rand();
      wb_write(`SD_ADR_ERROR_ISER, r);
      wb_read(`SD_ADR_ERROR_ISER, rd);
      check_word("error enable readback", {16'd0, r[15:0]}, rd);
      r = next_rand();
      wb_write(`SD_ADR_CLOCK_D, r);
      wb_read(`SD_ADR_CLOCK_D, rd);
      check_word("divider readback", {24'd0, r[7:0]}, rd);
      r = next_rand();
      wb_write(`SD_ADR_COMMAND, r);
      wb_read(`SD_ADR_COMMAND, rd);
      check_setting("command readback", sd_ctrl_pkg::cmd_setting_t'(r[15:0]),
                    sd_ctrl_pkg::cmd_setting_t'(rd[15:0]));
    end
    wb_write(`SD_ADR_TIMEOUT, TIMEOUT_VAL);
    wb_write(`SD_ADR_CLOCK_D, 32'(`SD_RESET_CLK_DIV));
    wb_write(`SD_ADR_NORMAL_ISER, 32'd0);
    wb_write(`SD_ADR_ERROR_ISER, 32'd0);
    report_test("test 1 register readback", first);

    first = errors;
    for (int i = 0; i < 4; i++) begin
      r                 = next_rand();
      setting           = sd_ctrl_pkg::cmd_setting_t'(r[31:16]);
      setting.resp_type = 2'd0;
      arg               = next_rand();
      launch_cmd(setting, arg);
      wait_idle();
      check_frame("no response frame", cmd_frame(setting.cmd_index, arg));
      check_done("no response", 32'd0, 1'b0, '0);
    end
    report_test("test 2 command frames", first);

    first = errors;
    for (int i = 0; i < 4; i++) begin
      r                   = next_rand();
      setting             = '0;
      setting.resp_type   = 2'd1;
      setting.crc_check   = 1'b1;
      setting.index_check = 1'b1;
      setting.cmd_index   = r[29:24];
      status              = next_rand();
      arm_card(setting.cmd_index, status, 7'd0, 1'b1, int'(r[19:16]));
      launch_cmd(setting, next_rand());
      wait_idle();
      check_done("short response", status, 1'b1, '0);
    end
    report_test("test 3 short responses", first);

    first = errors;
    for (int i = 0; i < 6; i++) begin
      fault               = i % 3;  // 0 CRC, 1 index, 2 end bit
      r                   = next_rand();
      setting             = '0;
      setting.resp_type   = 2'd1;
      setting.crc_check   = (i < 3);  // Each fault once checked, once masked
      setting.index_check = (i < 3);
      setting.cmd_index   = r[29:24];
      idx                 = (fault == 1) ? (r[29:24] ^ {r[13:9], 1'b1}) : r[29:24];
      status              = next_rand();
      arm_card(idx, status, (fault == 0) ? (r[6:0] | 7'h01) : 7'd0, fault != 2,
               int'(r[19:16]));
      launch_cmd(setting, next_rand());
      wait_idle();
      exp_err         = '0;
      exp_err.crc     = (fault == 0) && setting.crc_check;
      exp_err.index   = (fault == 1) && setting.index_check;
      exp_err.end_bit = (fault == 2);
      check_done("response fault", status, 1'b1, exp_err);
    end
    report_test("test 4 response faults", first);

    first = errors;
    wb_write(`SD_ADR_ERROR_ISER, 32'd0);
    r                 = next_rand();
    setting           = '0;
    setting.resp_type = 2'd1;
    setting.cmd_index = r[31:26];
    launch_cmd(setting, next_rand());  // Card stays silent
    wait_idle();
    exp_err         = '0;
    exp_err.timeout = 1'b1;
    check_done("silent card", 32'd0, 1'b0, exp_err);
    check_word("int_a masked", 32'd0, {31'd0, int_a});
    wb_write(`SD_ADR_NORMAL_ISER, 32'd1);
    check_word("int_a enabled", 32'd1, {31'd0, int_a});
    wb_write(`SD_ADR_NORMAL_ISR, 32'd0);
    wb_read(`SD_ADR_NORMAL_ISR, rd);
    check_word("normal status cleared", 32'd0, rd);
    check_word("int_a after clear", 32'd0, {31'd0, int_a});
    wb_write(`SD_ADR_NORMAL_ISER, 32'd0);
    check_word("int_b masked", 32'd0, {31'd0, int_b});
    wb_write(`SD_ADR_ERROR_ISER, 32'd1);
    check_word("int_b enabled", 32'd1, {31'd0, int_b});
    wb_write(`SD_ADR_ERROR_ISR, 32'd0);
    wb_read(`SD_ADR_ERROR_ISR, rd);
    check_word("error status cleared", 32'd0, rd);
    check_word("int_b after clear", 32'd0, {31'd0, int_b});
    wb_write(`SD_ADR_ERROR_ISER, 32'd0);
    report_test("test 5 response timeout", first);

    first = errors;
    r                 = next_rand();
    setting           = '0;
    setting.cmd_index = r[31:26];
    launch_cmd(setting, next_rand());
    while (tx_bits.size() < 10) @(negedge wb_clk_i);
    wb_write(`SD_ADR_SOFTWARE, 32'd1);
    check_word("oe in software reset", 32'd0, {31'd0, sd_cmd_oe_o});
    wb_read(`SD_ADR_STATUS, rd);
    check_word("busy in software reset", 32'd0, rd);
    wb_write(`SD_ADR_SOFTWARE, 32'd0);
    r                   = next_rand();
    setting             = '0;
    setting.resp_type   = 2'd1;
    setting.crc_check   = 1'b1;
    setting.index_check = 1'b1;
    setting.cmd_index   = r[29:24];
    status              = next_rand();
    arg                 = next_rand();
    arm_card(setting.cmd_index, status, 7'd0, 1'b1, int'(r[19:16]));
    launch_cmd(setting, arg);
    wait_idle();
    check_frame("frame after software reset", cmd_frame(setting.cmd_index, arg));
    check_done("after software reset", status, 1'b1, '0);
    report_test("test 6 software reset", first);

    $display("Tests run %0d, checks %0d, mismatches %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+common
common/sd_ctrl_pkg.sv
source/sd_clock_divider.sv
sd_cmd/sd_cmd_serial.sv
sd_cmd/sd_cmd_master.sv
source/sd_wb_regs.sv
source/sd_controller_top.sv
verification/sd_controller_tb.sv
